// File: common/an_pkg.sv
//////////////////////////////////////////////////
// Clause 37 auto-negotiation shared definitions
// Code-group bytes, config word layout, FSM types
//////////////////////////////////////////////////

package an_pkg;

  // Decoded code-group bytes used by the ordered sets
  localparam logic [7:0] k28_5 = 8'hbc;
  localparam logic [7:0] d21_5 = 8'hb5;
  localparam logic [7:0] d2_2  = 8'h42;
  localparam logic [7:0] d5_6  = 8'hc5;
  localparam logic [7:0] d16_2 = 8'h50;

  // Config register word as carried in C1/C2 ordered sets
  //   15 NP, 14 ACK, 13:12 RF, 8:7 PS, 6 HD, 5 FD
  typedef logic [15:0] config_reg_t;

  localparam int cfg_ack_bit = 14;

  // Transmit mode requested from the encoder
  typedef enum logic [1:0] {
    xmit_idle          = 2'd0,
    xmit_configuration = 2'd1,
    xmit_data          = 2'd2
  } xmit_t;

  // Arbitration states
  typedef enum logic [3:0] {
    an_enable               = 4'd0,
    an_restart              = 4'd1,
    an_disable_link_ok      = 4'd2,
    ability_detect          = 4'd3,
    ability_detect_wait     = 4'd4,
    acknowledge_detect      = 4'd5,
    acknowledge_detect_wait = 4'd6,
    complete_acknowledge    = 4'd7,
    idle_detect             = 4'd8,
    link_ok                 = 4'd9
  } an_state_t;

endpackage

// File: common/an_rx_status_if.sv
//////////////////////////////////////////////////
// Receive status between decoder, match logic and
// the arbitration FSM
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface an_rx_status_if ();
  import an_pkg::*;

  // From the ordered-set decoder
  logic        cfg_stb;
  config_reg_t cfg_word;
  logic        idle_stb;

  // From the match detectors
  logic ability_match;
  logic acknowledge_match;
  logic consistency_match;
  logic idle_match;

  // From arbitration
  logic clear_stb;
  logic capture_consistency;

  modport decode (output cfg_stb, cfg_word, idle_stb);

  modport match (
    input  cfg_stb, cfg_word, idle_stb, clear_stb, capture_consistency,
    output ability_match, acknowledge_match, consistency_match, idle_match
  );

  modport arb (
    input  cfg_word, ability_match, acknowledge_match, consistency_match, idle_match,
    output clear_stb, capture_consistency
  );

endinterface

// File: hw/an_rx/an_rx_decode.sv
//////////////////////////////////////////////////
// Received ordered-set decoder
// Finds C1/C2 and I1/I2, assembles config words
//////////////////////////////////////////////////

`timescale 1ns/1ps

module an_rx_decode (
  input logic          clk,
  input logic          mr_main_reset,
  input logic [7:0]    rx_byte,
  input logic          rx_is_k,
  an_rx_status_if.decode rx
);
  import an_pkg::*;

  typedef enum logic [1:0] {idle, got_k, cfg_low, cfg_high} dec_state_t;

  dec_state_t state;
  logic [7:0] low_byte;
  logic       is_k28_5;
  logic       is_cfg_marker;
  logic       is_idle_marker;

  assign is_k28_5       = rx_is_k && (rx_byte == k28_5);
  assign is_cfg_marker  = !rx_is_k && ((rx_byte == d21_5) || (rx_byte == d2_2));
  assign is_idle_marker = !rx_is_k && ((rx_byte == d5_6) || (rx_byte == d16_2));

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      state       <= idle;
      rx.cfg_stb  <= 1'b0;
      rx.idle_stb <= 1'b0;
      rx.cfg_word <= '0;
    end else begin
      rx.cfg_stb  <= 1'b0;
      rx.idle_stb <= 1'b0;
      case (state)
        idle: begin
          if (is_k28_5) state <= got_k;
        end
        got_k: begin
          if (is_cfg_marker) begin
            state <= cfg_low;
          end else if (is_idle_marker) begin
            state       <= idle;
            rx.idle_stb <= 1'b1;
          end else if (is_k28_5) begin
            state <= got_k;  // back-to-back comma, keep the newer one
          end else begin
            state <= idle;
          end
        end
        cfg_low: begin
          state <= cfg_high;
        end
        cfg_high: begin
          rx.cfg_word <= {rx_byte, low_byte};
          rx.cfg_stb  <= 1'b1;
          state       <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Low config byte waits here until the high byte arrives
  always_ff @(posedge clk) begin
    if (state == cfg_low) low_byte <= rx_byte;
  end

  stb_exclusive: assert property (@(posedge clk) disable iff (mr_main_reset)
    !(rx.cfg_stb && rx.idle_stb));

endmodule

// File: hw/an_rx/an_match_detect.sv
//////////////////////////////////////////////////
// Ability, acknowledge, consistency and idle match
// detectors with their repeat counters
//////////////////////////////////////////////////

`timescale 1ns/1ps

module an_match_detect (
  input logic           clk,
  input logic           mr_main_reset,
  an_rx_status_if.match rx
);
  import an_pkg::*;

  config_reg_t prev_word;
  config_reg_t cons_word;
  config_reg_t cur_masked;
  config_reg_t prev_masked;
  logic [1:0]  ability_cnt;
  logic [1:0]  ack_cnt;
  logic [1:0]  idle_cnt;
  logic        ability_rpt;
  logic        ack_rpt;

  // Ability match compares words with the ack bit ignored
  always_comb begin
    cur_masked               = rx.cfg_word;
    cur_masked[cfg_ack_bit]  = 1'b0;
    prev_masked              = prev_word;
    prev_masked[cfg_ack_bit] = 1'b0;
  end

  assign ability_rpt = (cur_masked == prev_masked);
  assign ack_rpt     = rx.cfg_word[cfg_ack_bit] && (rx.cfg_word == prev_word);

  // Word history, kept across state transitions
  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      prev_word <= '0;
      cons_word <= '0;
    end else if (rx.cfg_stb) begin
      prev_word <= rx.cfg_word;
      // Consistency word is kept with the ack bit cleared
      if (rx.capture_consistency) cons_word <= cur_masked;
    end
  end

  always_ff @(posedge clk) begin
    if (mr_main_reset || rx.clear_stb) begin
      rx.ability_match     <= 1'b0;
      rx.acknowledge_match <= 1'b0;
      rx.consistency_match <= 1'b0;
      rx.idle_match        <= 1'b0;
      ability_cnt          <= 2'd0;
      ack_cnt              <= 2'd0;
      idle_cnt             <= 2'd0;
    end else begin
      if (rx.cfg_stb && !rx.ability_match) begin
        if (!ability_rpt) begin
          ability_cnt <= 2'd0;
        end else if (ability_cnt == 2'd2) begin
          ability_cnt      <= 2'd0;
          rx.ability_match <= 1'b1;
        end else begin
          ability_cnt <= ability_cnt + 2'd1;
        end
      end
      if (rx.cfg_stb && !rx.acknowledge_match) begin
        if (!ack_rpt) begin
          ack_cnt <= 2'd0;
        end else if (ack_cnt == 2'd2) begin
          ack_cnt              <= 2'd0;
          rx.acknowledge_match <= 1'b1;
          // Partner must still offer what it offered during ability detect
          rx.consistency_match <= (cur_masked == cons_word);
        end else begin
          ack_cnt <= ack_cnt + 2'd1;
        end
      end
      if (rx.idle_stb && !rx.idle_match) begin
        if (idle_cnt == 2'd2) begin
          idle_cnt      <= 2'd0;
          rx.idle_match <= 1'b1;
        end else begin
          idle_cnt <= idle_cnt + 2'd1;
        end
      end
    end
  end

  consistency_needs_ack: assert property (@(posedge clk) disable iff (mr_main_reset)
    $rose(rx.consistency_match) |-> rx.acknowledge_match);

endmodule

// File: hw/link_timer.sv
//////////////////////////////////////////////////
// One-shot link timer, done after a fixed count
//////////////////////////////////////////////////

`timescale 1ns/1ps

module link_timer #(
  parameter int link_timer_ticks = 1250000
) (
  input  logic clk,
  input  logic mr_main_reset,
  input  logic start_stb,
  output logic running,
  output logic done
);

  localparam int cnt_w = (link_timer_ticks > 1) ? $clog2(link_timer_ticks) : 1;
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(link_timer_ticks - 1);

  logic [cnt_w-1:0] count;

  // Count returns to zero when a period ends
  assign done = (count == last_cnt);

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      running <= 1'b0;
      count   <= '0;
    end else if (!running) begin
      if (start_stb) running <= 1'b1;
    end else if (done) begin
      running <= 1'b0;
      count   <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  done_while_running: assert property (@(posedge clk) disable iff (mr_main_reset)
    done |-> running);

endmodule

// File: hw/an_arbitration.sv
//////////////////////////////////////////////////
// Clause 37 arbitration FSM
// Chooses transmit mode and transmitted config word
//////////////////////////////////////////////////

`timescale 1ns/1ps

module an_arbitration #(
  parameter an_pkg::config_reg_t adv_ability = 16'h0020
) (
  input  logic                clk,
  input  logic                mr_main_reset,
  input  logic                los,
  an_rx_status_if.arb         rx,
  output logic                timer_start,
  input  logic                timer_running,
  input  logic                timer_done,
  output an_pkg::xmit_t       xmit,
  output an_pkg::config_reg_t tx_config,
  output logic                tx_restart,
  output logic                negotiating,
  output an_pkg::config_reg_t lacr_rx_val
);
  import an_pkg::*;

  localparam config_reg_t ack_mask = config_reg_t'(1) << cfg_ack_bit;

  an_state_t state;
  logic      timer_idle;
  logic      breaklink;

  // Start pending counts as busy, the timer sees the strobe one clock late
  assign timer_idle = !timer_running && !timer_start;
  assign breaklink  = rx.ability_match && (rx.cfg_word == '0);

  assign rx.capture_consistency = (state == ability_detect) || (state == ability_detect_wait);
  assign negotiating = (state != link_ok);
  assign lacr_rx_val = rx.cfg_word;

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      state        <= an_enable;
      xmit         <= xmit_data;
      tx_config    <= '0;
      timer_start  <= 1'b0;
      tx_restart   <= 1'b0;
      rx.clear_stb <= 1'b0;
    end else begin
      timer_start  <= 1'b0;
      tx_restart   <= 1'b0;
      rx.clear_stb <= 1'b0;
      case (state)
        an_enable: begin
          tx_restart   <= 1'b1;
          rx.clear_stb <= 1'b1;
          if (los) begin
            xmit  <= xmit_data;
            state <= an_disable_link_ok;
          end else begin
            tx_config <= '0;
            xmit      <= xmit_configuration;
            state     <= an_restart;
          end
        end
        an_restart: begin
          // Breaklink is sent for a full link timer period
          if (timer_idle) begin
            timer_start <= 1'b1;
          end else if (timer_done) begin
            state        <= ability_detect;
            rx.clear_stb <= 1'b1;
          end
        end
        an_disable_link_ok: begin
          if (!los) begin
            state        <= an_enable;
            rx.clear_stb <= 1'b1;
          end
        end
        ability_detect: begin
          tx_config    <= adv_ability & ~ack_mask;
          state        <= ability_detect_wait;
          rx.clear_stb <= 1'b1;
        end
        ability_detect_wait: begin
          if (rx.ability_match) begin
            state        <= breaklink ? an_enable : acknowledge_detect;
            rx.clear_stb <= 1'b1;
          end
        end
        acknowledge_detect: begin
          tx_config <= tx_config | ack_mask;
          state     <= acknowledge_detect_wait;
        end
        acknowledge_detect_wait: begin
          if (breaklink || (rx.acknowledge_match && !rx.consistency_match)) begin
            state        <= an_enable;
            rx.clear_stb <= 1'b1;
          end else if (rx.acknowledge_match) begin
            state        <= complete_acknowledge;
            rx.clear_stb <= 1'b1;
          end
        end
        complete_acknowledge: begin
          if (timer_idle) begin
            timer_start <= 1'b1;
          end else if (breaklink) begin
            state        <= an_enable;
            rx.clear_stb <= 1'b1;
          end else if (timer_done) begin
            state        <= idle_detect;
            rx.clear_stb <= 1'b1;
          end
        end
        idle_detect: begin
          // Timer reruns until the partner's idles have been seen
          if (timer_idle) begin
            timer_start <= 1'b1;
            xmit        <= xmit_idle;
          end else if (breaklink) begin
            state        <= an_enable;
            rx.clear_stb <= 1'b1;
          end else if (timer_done && rx.idle_match) begin
            xmit         <= xmit_data;
            state        <= link_ok;
            rx.clear_stb <= 1'b1;
          end
        end
        link_ok: begin
          if (rx.ability_match) begin
            state        <= an_enable;
            rx.clear_stb <= 1'b1;
          end
        end
        default: state <= an_enable;
      endcase
    end
  end

  data_in_link_ok: assert property (@(posedge clk) disable iff (mr_main_reset)
    (state == link_ok) |-> (xmit == xmit_data));

endmodule

// File: hw/an_tx_encode.sv
//////////////////////////////////////////////////
// Transmit encoder, one byte per clock
// Config sets, alternating idle sets or data zeros
//////////////////////////////////////////////////

`timescale 1ns/1ps

module an_tx_encode (
  input  logic                clk,
  input  logic                mr_main_reset,
  input  an_pkg::xmit_t       xmit,
  input  an_pkg::config_reg_t tx_config,
  input  logic                restart_stb,
  output logic [7:0]          tx_byte,
  output logic                tx_is_k
);
  import an_pkg::*;

  xmit_t       xmit_q;
  config_reg_t word_q;
  logic [1:0]  byte_cnt;
  logic [1:0]  cur_cnt;
  logic        variant;
  logic        cur_var;
  logic        new_set;

  // A mode change or restart begins a fresh ordered set on this edge
  assign new_set = restart_stb || (xmit != xmit_q);
  assign cur_cnt = new_set ? 2'd0 : byte_cnt;
  assign cur_var = new_set ? 1'b0 : variant;

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      xmit_q   <= xmit_data;
      byte_cnt <= 2'd0;
      variant  <= 1'b0;
      tx_byte  <= 8'h00;
      tx_is_k  <= 1'b0;
    end else begin
      xmit_q <= xmit;
      case (xmit)
        xmit_configuration: begin
          byte_cnt <= cur_cnt + 2'd1;
          tx_is_k  <= (cur_cnt == 2'd0);
          case (cur_cnt)
            2'd0: tx_byte <= k28_5;
            2'd1: begin
              tx_byte <= cur_var ? d21_5 : d2_2;
              variant <= ~cur_var;
            end
            2'd2: tx_byte <= word_q[7:0];
            default: tx_byte <= word_q[15:8];
          endcase
        end
        xmit_idle: begin
          // Two-byte sets, I1 and I2 alternate
          byte_cnt <= {1'b0, ~cur_cnt[0]};
          tx_is_k  <= !cur_cnt[0];
          if (!cur_cnt[0]) begin
            tx_byte <= k28_5;
          end else begin
            tx_byte <= cur_var ? d16_2 : d5_6;
            variant <= ~cur_var;
          end
        end
        default: begin
          byte_cnt <= 2'd0;
          variant  <= 1'b0;
          tx_byte  <= 8'h00;
          tx_is_k  <= 1'b0;
        end
      endcase
    end
  end

  // Word is sampled at the comma so both bytes come from one value
  always_ff @(posedge clk) begin
    if ((xmit == xmit_configuration) && (cur_cnt == 2'd0)) word_q <= tx_config;
  end

endmodule

// File: hw/an_clause37_top.sv
//////////////////////////////////////////////////
// Clause 37 auto-negotiation top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module an_clause37_top #(
  parameter int                  link_timer_ticks = 1250000,
  parameter an_pkg::config_reg_t adv_ability      = 16'h0020
) (
  input  logic                clk,
  input  logic                mr_main_reset,
  input  logic [7:0]          rx_byte,
  input  logic                rx_is_k,
  input  logic                los,
  output logic [7:0]          tx_byte,
  output logic                tx_is_k,
  output logic                negotiating,
  output an_pkg::config_reg_t lacr_rx_val
);
  import an_pkg::*;

  an_rx_status_if rx_if ();

  logic        timer_start;
  logic        timer_running;
  logic        timer_done;
  xmit_t       xmit;
  config_reg_t tx_config;
  logic        tx_restart;

  an_rx_decode u_an_rx_decode (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .rx_byte       (rx_byte),
    .rx_is_k       (rx_is_k),
    .rx            (rx_if)
  );

  an_match_detect u_an_match_detect (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .rx            (rx_if)
  );

  link_timer #(
    .link_timer_ticks (link_timer_ticks)
  ) u_link_timer (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .start_stb     (timer_start),
    .running       (timer_running),
    .done          (timer_done)
  );

  an_arbitration #(
    .adv_ability (adv_ability)
  ) u_an_arbitration (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .los           (los),
    .rx            (rx_if),
    .timer_start   (timer_start),
    .timer_running (timer_running),
    .timer_done    (timer_done),
    .xmit          (xmit),
    .tx_config     (tx_config),
    .tx_restart    (tx_restart),
    .negotiating   (negotiating),
    .lacr_rx_val   (lacr_rx_val)
  );

  an_tx_encode u_an_tx_encode (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .xmit          (xmit),
    .tx_config     (tx_config),
    .restart_stb   (tx_restart),
    .tx_byte       (tx_byte),
    .tx_is_k       (tx_is_k)
  );

endmodule

// File: bench/an_tb.sv
//////////////////////////////////////////////////
// Clause 37 auto-negotiation testbench
// Plays a link partner from the test data file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module an_tb;
  import an_pkg::*;

  localparam int          ticks    = 64;
  localparam int          limit    = 20 * ticks;
  localparam config_reg_t adv_word = 16'h0020;
  localparam config_reg_t ack_flag = 16'h4000;

  logic        clk;
  logic        mr_main_reset;
  logic [7:0]  rx_byte;
  logic        rx_is_k;
  logic        los;
  logic [7:0]  tx_byte;
  logic        tx_is_k;
  logic        negotiating;
  config_reg_t lacr_rx_val;

  int          value_errors;
  int          timeout_errors;
  string       cur_name;

  // Partner modes: 0 data zeros, 1 config sets, 2 idle sets
  int          partner_mode;
  config_reg_t partner_word;

  // Transmit monitor state
  int          mon_pos;
  logic [7:0]  mon_low;
  config_reg_t last_tx_cfg;
  int          cfg_cnt;
  int          idle_cnt;
  int          zero_run;
  logic [7:0]  idle_next;

  an_clause37_top #(
    .link_timer_ticks (ticks)
  ) u_an_clause37_top (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .rx_byte       (rx_byte),
    .rx_is_k       (rx_is_k),
    .los           (los),
    .tx_byte       (tx_byte),
    .tx_is_k       (tx_is_k),
    .negotiating   (negotiating),
    .lacr_rx_val   (lacr_rx_val)
  );

  initial begin
    clk           = 1'b0;
    mr_main_reset = 1'b1;
    rx_byte       = 8'h00;
    rx_is_k       = 1'b0;
    los           = 1'b0;
    partner_mode  = 0;
    partner_word  = '0;
    forever #10 clk = ~clk;
  end

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_config(input string name, input config_reg_t exp, input config_reg_t act);
    if (exp !== act) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAILED %s expected %b actual %b", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic drive_byte(input logic [7:0] b, input logic k);
    @(negedge clk);
    rx_byte = b;
    rx_is_k = k;
  endtask

  // Link partner, same ordered-set format as the encoder
  initial begin : partner
    config_reg_t w;
    logic        alt;
    alt = 1'b0;
    forever begin
      if (partner_mode == 1) begin
        w = partner_word;
        drive_byte(k28_5, 1'b1);
        drive_byte(alt ? d21_5 : d2_2, 1'b0);
        drive_byte(w[7:0], 1'b0);
        drive_byte(w[15:8], 1'b0);
      end else if (partner_mode == 2) begin
        drive_byte(k28_5, 1'b1);
        drive_byte(alt ? d16_2 : d5_6, 1'b0);
      end else begin
        drive_byte(8'h00, 1'b0);
      end
      alt = ~alt;
    end
  end

  // Parses the transmitted stream into config words and idle sets
  always @(posedge clk) begin
    if (mr_main_reset) begin
      mon_pos   = 0;
      zero_run  = 0;
      idle_next = d5_6;
    end else begin
      zero_run = (!tx_is_k && tx_byte == 8'h00 && mon_pos == 0) ? zero_run + 1 : 0;
      case (mon_pos)
        1: begin
          if (!tx_is_k && (tx_byte == d21_5 || tx_byte == d2_2)) begin
            mon_pos = 2;
          end else if (!tx_is_k && (tx_byte == d5_6 || tx_byte == d16_2)) begin
            check_byte({cur_name, " idle byte"}, idle_next, tx_byte);
            idle_next = (tx_byte == d5_6) ? d16_2 : d5_6;
            idle_cnt++;
            mon_pos = 0;
          end else if (!(tx_is_k && tx_byte == k28_5)) begin
            mon_pos = 0;
          end
        end
        2: begin
          // A comma here means the encoder cut the config set short
          if (tx_is_k && tx_byte == k28_5) begin
            mon_pos = 1;
          end else begin
            mon_low = tx_byte;
            mon_pos = 3;
          end
        end
        3: begin
          if (tx_is_k && tx_byte == k28_5) begin
            mon_pos = 1;
          end else begin
            last_tx_cfg = {tx_byte, mon_low};
            cfg_cnt++;
            idle_next = d5_6;
            mon_pos   = 0;
          end
        end
        default: begin
          if (tx_is_k && tx_byte == k28_5) mon_pos = 1;
        end
      endcase
    end
  end

  task automatic apply_reset();
    mr_main_reset = 1'b1;
    repeat (10) @(negedge clk);
    mr_main_reset = 1'b0;
  endtask

  task automatic wait_tx_config(input config_reg_t exp);
    int start;
    int i;
    start = cfg_cnt;
    i = 0;
    while (!(cfg_cnt != start && last_tx_cfg == exp) && i < limit) begin
      @(negedge clk);
      i++;
    end
    if (i >= limit) begin
      $display("%s: timed out waiting for transmitted config word %h", cur_name, exp);
      timeout_errors++;
    end
  endtask

  task automatic wait_tx_idle();
    int start;
    int i;
    start = idle_cnt;
    i = 0;
    while (idle_cnt == start && i < limit) begin
      @(negedge clk);
      i++;
    end
    if (i >= limit) begin
      $display("%s: timed out waiting for transmitted idle sets", cur_name);
      timeout_errors++;
    end
  endtask

  task automatic wait_tx_data();
    int i;
    i = 0;
    while (zero_run < 8 && i < limit) begin
      @(negedge clk);
      i++;
    end
    if (i >= limit) begin
      $display("%s: timed out waiting for data zero bytes", cur_name);
      timeout_errors++;
    end
  endtask

  task automatic run_test(input logic t_los, input config_reg_t ability, input config_reg_t ack,
                          input config_reg_t exp_lacr, input logic exp_neg);
    los          = t_los;
    partner_word = ability;
    partner_mode = t_los ? 0 : 1;
    apply_reset();
    if (t_los) begin
      // Disabled link must stay silent for several timer periods
      repeat (4 * ticks) begin
        @(negedge clk);
        check_flag({cur_name, " negotiating"}, exp_neg, negotiating);
        check_byte({cur_name, " tx_byte"}, 8'h00, tx_byte);
        check_flag({cur_name, " tx_is_k"}, 1'b0, tx_is_k);
      end
      check_config({cur_name, " lacr_rx_val"}, exp_lacr, lacr_rx_val);
    end else begin
      wait_tx_config(16'h0000);
      wait_tx_config(adv_word & ~ack_flag);
      wait_tx_config(adv_word | ack_flag);
      check_config({cur_name, " ability lacr"}, ability, lacr_rx_val);
      partner_word = ack;
      if (ack == (ability | ack_flag)) begin
        wait_tx_idle();
        partner_mode = 2;
        wait_tx_data();
        check_flag({cur_name, " negotiating"}, exp_neg, negotiating);
        check_config({cur_name, " lacr_rx_val"}, exp_lacr, lacr_rx_val);
        // Partner breaklink from link ok
        partner_word = '0;
        partner_mode = 1;
        wait_tx_config(16'h0000);
        check_flag({cur_name, " breaklink negotiating"}, 1'b1, negotiating);
      end else begin
        wait_tx_config(16'h0000);
        check_flag({cur_name, " negotiating"}, exp_neg, negotiating);
        check_config({cur_name, " lacr_rx_val"}, exp_lacr, lacr_rx_val);
      end
    end
  endtask

  initial begin : main
    int          fd;
    int          n;
    string       line;
    string       name;
    logic        t_los;
    config_reg_t ability;
    config_reg_t ack;
    config_reg_t exp_lacr;
    logic        exp_neg;
    value_errors   = 0;
    timeout_errors = 0;
    cfg_cnt        = 0;
    idle_cnt       = 0;
    last_tx_cfg    = '0;
    cur_name       = "reset";
    fd = $fopen("bench/an_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      timeout_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h", name, t_los, ability, ack, exp_lacr, exp_neg);
          if (n == 6) begin
            cur_name = name;
            run_test(t_los, ability, ack, exp_lacr, exp_neg);
          end
        end
      end
      $fclose(fd);
    end
    $display("Value errors: %0d, timeouts and other errors: %0d", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: bench/an_testdata.txt
# Columns: name los partner_ability partner_ack expected_lacr_rx_val expected_negotiating
# All values after the name are hex; ack equal to ability plus bit 14 completes the link
link_fd 0 0020 4020 4020 0
link_hd_fd 0 0060 4060 4060 0
link_pause 0 01a0 41a0 41a0 0
link_remote_fault 0 3020 7020 7020 0
ack_mismatch 0 0020 4060 4060 1
ack_wrong_pause 0 0060 4160 4160 1
los_on 1 0020 4020 0000 1

// File: compile.f
common/an_pkg.sv
common/an_rx_status_if.sv
hw/an_rx/an_rx_decode.sv
hw/an_rx/an_match_detect.sv
hw/link_timer.sv
hw/an_arbitration.sv
hw/an_tx_encode.sv
hw/an_clause37_top.sv
bench/an_tb.sv
